// File: all.f
+incdir+dv
source/couple_pkg.sv
source/coupling_regs.sv
source/iq_decode.sv
source/cordic_rotate.sv
source/couple_result.sv
source/pair_couple_top.sv
dv/pair_couple_tb.sv

// File: dv/couple_vectors.svh
`ifndef COUPLE_VECTORS_SVH
`define COUPLE_VECTORS_SVH

// Columns: mag0, mag1, off0, off1, drive I, drive Q, lo_phase, tolerance
// Magnitudes stay within about 0.6 of full scale, since larger ones wrap
// at the rotator output after the CORDIC gain
typedef struct packed {
	int mag0;
	int mag1;
	int off0;
	int off1;
	int drv_i;
	int drv_q;
	int lo;
	int tol;
} vec_row_t;

// Gain of an 18-stage CORDIC, the product of sqrt(1 + 2**-2i)
localparam real CORDIC_GAIN = 1.6467602581210654;
localparam real TWO_PI = 6.283185307179586;

localparam int DIRECTED_ROWS = 14;

localparam vec_row_t DIRECTED_TABLE [0:DIRECTED_ROWS-1] = '{
	// Zero couplings with a live drive must give an exact zero
	'{0, 0, 0, 0, 100000, -50000, 0, 0},
	// Pure I drive at zero phase
	'{40000, 70000, 0, 0, 120000, 0, 0, 16},
	// LO phase at each quadrant boundary
	'{60000, -30000, 0, 0, 100000, 0, 0, 24},
	'{60000, -30000, 0, 0, 100000, 0, 131072, 24},
	'{60000, -30000, 0, 0, 100000, 0, 262144, 24},
	'{60000, -30000, 0, 0, 100000, 0, 393216, 24},
	// LO phase inside the second, third and fourth quadrants
	'{60000, -30000, 0, 0, 100000, 0, 200000, 24},
	'{60000, -30000, 0, 0, 100000, 0, 300000, 24},
	'{60000, -30000, 0, 0, 100000, 0, 450000, 24},
	// Same magnitude, different offsets per entry
	'{50000, 50000, 0, 87381, 110000, 0, 0, 24},
	'{50000, 50000, 174763, 436907, 110000, 0, 65536, 24},
	// Complex drive with negative magnitudes
	'{45000, -65000, 12000, 250000, 80000, -90000, 30000, 24},
	'{-77000, 33000, 500000, 70000, -110000, 70000, 410000, 32},
	// Result well past the 18-bit range in both directions
	'{78000, -78000, 0, 0, 131071, 131071, 458752, 40}
};

// Real part of (mag * G * e^(j*theta)) * (I + jQ), scaled down by 2**17
// where theta is the LO phase plus the offset in fractions of a circle
function automatic int model_pair(input int mag, input int off, input int di,
	input int dq, input int lo);
	real theta;
	real amp;
	real ang;
	real val;
	theta = TWO_PI * $itor(lo + off) / $itor(1 << couple_pkg::PHASE_W);
	amp = CORDIC_GAIN * $itor(mag) * $sqrt($itor(di) * $itor(di) + $itor(dq) * $itor(dq));
	ang = $atan2($itor(dq), $itor(di));
	val = amp * $cos(ang + theta) / $itor(1 << (couple_pkg::DATA_W - 1));
	// Round to nearest, away from zero on a tie
	return (val >= 0.0) ? $rtoi(val + 0.5) : $rtoi(val - 0.5);
endfunction

`endif

// File: dv/pair_couple_tb.sv
`timescale 1ns/1ps

module pair_couple_tb;

	localparam int CLK_PERIOD = 4;
	localparam int RANDOM_ROWS = 20;

	`include "couple_vectors.svh"

	logic                                  clk;
	logic                                  rst;
	logic                                  iq;
	logic signed [couple_pkg::DATA_W-1:0]  drive;
	logic [couple_pkg::PHASE_W-1:0]        lo_phase;
	logic                                  cfg_we;
	logic [couple_pkg::COUPLE_AW-1:0]      cfg_addr;
	logic signed [couple_pkg::DATA_W-1:0]  cfg_mag;
	logic [couple_pkg::PHASE_W-1:0]        cfg_offset;
	logic signed [couple_pkg::OUT_W-1:0]   pair;

	// Drive values that the stream puts out on the I and Q slots
	int cur_i;
	int cur_q;
	vec_row_t rows [$];

	pair_couple_top DUT (
		.clk        (clk),
		.rst        (rst),
		.iq         (iq),
		.drive      (drive),
		.lo_phase   (lo_phase),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_mag    (cfg_mag),
		.cfg_offset (cfg_offset),
		.pair       (pair)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// One clock of the interleaved stream
	// Q goes out on the cycle before iq is high, I on the cycle where it is
	task automatic tick();
		@(posedge clk);
		iq    <= ~iq;
		drive <= iq ? cur_q[couple_pkg::DATA_W-1:0] : cur_i[couple_pkg::DATA_W-1:0];
	endtask

	task automatic check_value(input string label, input int observed, input int expected,
		input int tol);
		int diff;
		diff = observed - expected;
		if (diff < 0)
			diff = -diff;
		if (diff > tol) begin
			$display("error at %0t ns: %s observed %0d expected %0d tolerance %0d",
				$time, label, observed, expected, tol);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch in %s", label);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("The testbench timed out while waiting for %s", what);
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	endtask

	// Let the pipeline run n cycles, bounded by simulated time as well
	task automatic run_cycles(input int n);
		int count;
		longint t_start;
		count = 0;
		t_start = $time;
		while (count < n) begin
			tick();
			count++;
			if ($time - t_start > longint'((n + 4) * CLK_PERIOD))
				report_timeout("the pipeline to settle");
		end
	endtask

	// Step until iq shows the requested level, then sample pair mid-cycle
	task automatic wait_for_iq(input logic level, output int observed);
		int tries;
		logic found;
		tries = 0;
		found = 1'b0;
		observed = 0;
		while (!found && tries < 4) begin
			tick();
			@(negedge clk);
			tries++;
			if (iq == level) begin
				found = 1'b1;
				observed = int'(pair);
			end
		end
		if (!found)
			report_timeout($sformatf("iq to go to %0d", level));
	endtask

	// Hold rst high for ten clock edges while the stream keeps running
	task automatic hold_reset();
		int n;
		rst <= 1'b1;
		for (n = 0; n < 10; n++)
			tick();
		rst <= 1'b0;
	endtask

	// Full-scale drive, magnitudes kept inside the rotator output range
	function automatic vec_row_t random_row();
		vec_row_t row;
		row.mag0  = int'($urandom_range(156000)) - 78000;
		row.mag1  = int'($urandom_range(156000)) - 78000;
		row.off0  = int'($urandom_range(524287));
		row.off1  = int'($urandom_range(524287));
		row.drv_i = int'($urandom_range(262142)) - 131071;
		row.drv_q = int'($urandom_range(262142)) - 131071;
		row.lo    = int'($urandom_range(524287));
		row.tol   = 40;
		return row;
	endfunction

	// Write both entries and switch the stream to the row's drive and phase
	task automatic load_row(input vec_row_t row);
		tick();
		cfg_we     <= 1'b1;
		cfg_addr   <= 1'b0;
		cfg_mag    <= row.mag0[couple_pkg::DATA_W-1:0];
		cfg_offset <= row.off0[couple_pkg::PHASE_W-1:0];
		lo_phase   <= row.lo[couple_pkg::PHASE_W-1:0];
		cur_i = row.drv_i;
		cur_q = row.drv_q;
		tick();
		cfg_addr   <= 1'b1;
		cfg_mag    <= row.mag1[couple_pkg::DATA_W-1:0];
		cfg_offset <= row.off1[couple_pkg::PHASE_W-1:0];
		tick();
		cfg_we <= 1'b0;
	endtask

	// Load a row, hold the stream steady and check both slots
	task automatic apply_row(input int r, input vec_row_t row);
		int expect0;
		int expect1;
		int observed;
		expect0 = model_pair(row.mag0, row.off0, row.drv_i, row.drv_q, row.lo);
		expect1 = model_pair(row.mag1, row.off1, row.drv_i, row.drv_q, row.lo);
		load_row(row);
		run_cycles(2 * couple_pkg::PIPE_LAT);
		// iq high carries entry 1, iq low carries entry 0
		wait_for_iq(1'b1, observed);
		check_value($sformatf("row %0d entry 1", r), observed, expect1, row.tol);
		wait_for_iq(1'b0, observed);
		check_value($sformatf("row %0d entry 0", r), observed, expect0, row.tol);
	endtask

	initial begin
		int r;
		void'($urandom(44491));
		rst        = 1'b1;
		iq         = 1'b0;
		drive      = '0;
		lo_phase   = '0;
		cfg_we     = 1'b0;
		cfg_addr   = '0;
		cfg_mag    = '0;
		cfg_offset = '0;
		cur_i = 0;
		cur_q = 0;

		for (r = 0; r < DIRECTED_ROWS; r++)
			rows.push_back(DIRECTED_TABLE[r]);
		for (r = 0; r < RANDOM_ROWS; r++)
			rows.push_back(random_row());

		hold_reset();

		// Fill the bank and the pipeline with live data, so the second
		// reset has nonzero state to clear
		load_row(DIRECTED_TABLE[1]);
		run_cycles(couple_pkg::PIPE_LAT);
		hold_reset();

		// Everything was cleared, so pair holds zero through the pipeline
		for (r = 0; r < couple_pkg::PIPE_LAT; r++) begin
			tick();
			@(negedge clk);
			check_value("pair after reset", int'(pair), 0, 0);
		end

		for (r = 0; r < rows.size(); r++)
			apply_row(r, rows[r]);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the pair coupling testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
SIM=pair_couple_sim

verilator --binary --timing -Wno-fatal -j 0 \
	--top-module pair_couple_tb \
	-Mdir "$BUILD_DIR" -o "$SIM" \
	-f all.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi

// File: source/cordic_rotate.sv
`timescale 1ns/1ps

// Execute stage
// Fully unrolled CORDIC in rotation mode. The vector (mag, 0) is turned
// by phase, so X and Y come out as mag*cos and mag*sin times the CORDIC
// gain of about 1.647. The gain is left in on purpose, the couplings
// are scaled with it in mind
module cordic_rotate (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic signed [couple_pkg::DATA_W-1:0]  mag,
	input  logic [couple_pkg::PHASE_W-1:0]        phase,
	output logic signed [couple_pkg::DATA_W-1:0]  xout,
	output logic signed [couple_pkg::DATA_W-1:0]  yout
);

	// Vector and residual angle at the input of each stage
	// Index 0 is the input register, index CORDIC_STAGES the last stage
	logic signed [couple_pkg::CORDIC_XW-1:0] x_pipe [0:couple_pkg::CORDIC_STAGES];
	logic signed [couple_pkg::CORDIC_XW-1:0] y_pipe [0:couple_pkg::CORDIC_STAGES];
	// The last stage has no use for its angle, so one fewer entry here
	logic signed [couple_pkg::PHASE_W-1:0]   z_pipe [0:couple_pkg::CORDIC_STAGES-1];

	// Set when the phase lies in the left half-plane
	logic fold;

	// Magnitude widened by one growth bit and shifted up by the guard bits
	logic signed [couple_pkg::CORDIC_XW-1:0] mag_ext;

	// Top two phase bits 01 and 10 are the second and third quadrants
	assign fold = phase[couple_pkg::PHASE_W-1] ^ phase[couple_pkg::PHASE_W-2];

	assign mag_ext = $signed({
		{(couple_pkg::CORDIC_XW - couple_pkg::DATA_W - couple_pkg::CORDIC_GUARD)
			{mag[couple_pkg::DATA_W-1]}},
		mag,
		{couple_pkg::CORDIC_GUARD{1'b0}}
	});

	// Input register
	// Rotating -v by (phase - half circle) equals rotating v by phase,
	// which brings the angle inside +/- a quarter circle where the
	// micro-rotations converge. Flipping the phase MSB subtracts the half
	// circle, and the extra growth bit keeps the negation of the most
	// negative magnitude from wrapping
	always_ff @(posedge clk) begin
		if (rst) begin
			x_pipe[0] <= '0;
			y_pipe[0] <= '0;
			z_pipe[0] <= '0;
		end else begin
			x_pipe[0] <= fold ? -mag_ext : mag_ext;
			// Start vector lies on the X axis
			y_pipe[0] <= '0;
			z_pipe[0] <= $signed({phase[couple_pkg::PHASE_W-1] ^ fold,
				phase[couple_pkg::PHASE_W-2:0]});
		end
	end

	// Micro-rotation stages
	for (genvar i = 0; i < couple_pkg::CORDIC_STAGES; i++) begin : g_stage

		// Each stage turns the vector by +/- atan(2**-i) toward zero residual
		always_ff @(posedge clk) begin
			if (rst) begin
				x_pipe[i+1] <= '0;
				y_pipe[i+1] <= '0;
			end else if (!z_pipe[i][couple_pkg::PHASE_W-1]) begin
				// Residual positive, turn counter-clockwise
				x_pipe[i+1] <= x_pipe[i] - (y_pipe[i] >>> i);
				y_pipe[i+1] <= y_pipe[i] + (x_pipe[i] >>> i);
			end else begin
				x_pipe[i+1] <= x_pipe[i] + (y_pipe[i] >>> i);
				y_pipe[i+1] <= y_pipe[i] - (x_pipe[i] >>> i);
			end
		end

		// Residual angle update, only where a later stage still reads it
		if (i < couple_pkg::CORDIC_STAGES - 1) begin : g_angle
			always_ff @(posedge clk) begin
				if (rst) begin
					z_pipe[i+1] <= '0;
				end else if (!z_pipe[i][couple_pkg::PHASE_W-1]) begin
					z_pipe[i+1] <= z_pipe[i] - $signed(couple_pkg::CORDIC_ATAN[i]);
				end else begin
					z_pipe[i+1] <= z_pipe[i] + $signed(couple_pkg::CORDIC_ATAN[i]);
				end
			end
		end

	end

	// Output rounding
	// Drop the guard bits with round-half-up. The growth bit is dropped too,
	// so magnitudes above about 0.6 of full scale wrap after the gain
	assign xout = x_pipe[couple_pkg::CORDIC_STAGES][couple_pkg::CORDIC_GUARD +: couple_pkg::DATA_W]
		+ {{(couple_pkg::DATA_W-1){1'b0}},
		x_pipe[couple_pkg::CORDIC_STAGES][couple_pkg::CORDIC_GUARD-1]};

	assign yout = y_pipe[couple_pkg::CORDIC_STAGES][couple_pkg::CORDIC_GUARD +: couple_pkg::DATA_W]
		+ {{(couple_pkg::DATA_W-1){1'b0}},
		y_pipe[couple_pkg::CORDIC_STAGES][couple_pkg::CORDIC_GUARD-1]};

endmodule

// File: source/couple_pkg.sv
package couple_pkg;

	// Drive samples, coupling magnitudes and rotator X/Y all share this width
	localparam int DATA_W = 18;

	// Phase words cover one full circle in 2**PHASE_W steps
	localparam int PHASE_W = 19;

	// The pair output keeps one extra MSB above the data width
	localparam int OUT_W = DATA_W + 1;

	// Full signed product of two data words
	localparam int PROD_W = 2 * DATA_W;

	// Number of micro-rotations in the unrolled rotator
	localparam int CORDIC_STAGES = 18;

	// One input register in front of the micro-rotation stages
	localparam int CORDIC_LAT = CORDIC_STAGES + 1;

	// Rotator sample to pair output, rotator plus three result levels
	localparam int PIPE_LAT = CORDIC_LAT + 3;

	// Fraction bits carried below the output LSB inside the rotator
	localparam int CORDIC_GUARD = 2;

	// Rotator X/Y width, one growth bit for the gain plus the guard bits
	localparam int CORDIC_XW = DATA_W + 1 + CORDIC_GUARD;

	// Two coupling entries, one address bit
	localparam int N_COUPLE = 2;
	localparam int COUPLE_AW = $clog2(N_COUPLE);

	// Arctangent of 2**-i, in units of a full circle over 2**PHASE_W
	localparam logic [PHASE_W-1:0] CORDIC_ATAN [0:CORDIC_STAGES-1] = '{
		19'd65536, 19'd38688, 19'd20442, 19'd10377,
		19'd5208,  19'd2607,  19'd1304,  19'd652,
		19'd326,   19'd163,   19'd81,    19'd41,
		19'd20,    19'd10,    19'd5,     19'd3,
		19'd1,     19'd1
	};

endpackage

// File: source/couple_result.sv
`timescale 1ns/1ps

// Result stage
// Real part of (xout + j*yout) * (d_real + j*d_imag), which is
// xout*d_real - yout*d_imag
module couple_result (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic signed [couple_pkg::DATA_W-1:0]  xout,
	input  logic signed [couple_pkg::DATA_W-1:0]  yout,
	input  logic signed [couple_pkg::DATA_W-1:0]  d_real,
	input  logic signed [couple_pkg::DATA_W-1:0]  d_imag,
	output logic signed [couple_pkg::OUT_W-1:0]   pair
);

	// Full products, one hard multiplier each
	logic signed [couple_pkg::PROD_W-1:0] prod_x;
	logic signed [couple_pkg::PROD_W-1:0] prod_y;

	// Truncated products after the second register level
	logic signed [couple_pkg::DATA_W-1:0] prod_x_t;
	logic signed [couple_pkg::DATA_W-1:0] prod_y_t;

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_x   <= '0;
			prod_y   <= '0;
			prod_x_t <= '0;
			prod_y_t <= '0;
			pair     <= '0;
		end else begin
			prod_x <= xout * d_real;
			prod_y <= yout * d_imag;
			// Keep bits 34 down to 17, the top bit only matters for the
			// single full-scale negative times full-scale negative case
			prod_x_t <= prod_x[couple_pkg::PROD_W-2 -: couple_pkg::DATA_W];
			prod_y_t <= prod_y[couple_pkg::PROD_W-2 -: couple_pkg::DATA_W];
			// Sign-extend by one bit so the difference never wraps
			// The output is not saturated, a later sum can absorb the extra MSB
			pair <= {prod_x_t[couple_pkg::DATA_W-1], prod_x_t}
				- {prod_y_t[couple_pkg::DATA_W-1], prod_y_t};
		end
	end

endmodule

// File: source/coupling_regs.sv
`timescale 1ns/1ps

// Register bank with the coupling magnitude and phase offset of each entry
module coupling_regs (
	input  logic                                  clk,
	input  logic                                  rst,
	// Host write port, both fields of one entry per strobe
	input  logic                                  cfg_we,
	input  logic [couple_pkg::COUPLE_AW-1:0]      cfg_addr,
	input  logic signed [couple_pkg::DATA_W-1:0]  cfg_mag,
	input  logic [couple_pkg::PHASE_W-1:0]        cfg_offset,
	// Independent read addresses for the two fields
	input  logic [couple_pkg::COUPLE_AW-1:0]      mag_addr,
	input  logic [couple_pkg::COUPLE_AW-1:0]      offset_addr,
	output logic signed [couple_pkg::DATA_W-1:0]  mag,
	output logic [couple_pkg::PHASE_W-1:0]        offset
);

	// Magnitudes are signed so a coupling can flip the field polarity
	logic signed [couple_pkg::DATA_W-1:0] mag_mem    [0:couple_pkg::N_COUPLE-1];
	logic [couple_pkg::PHASE_W-1:0]       offset_mem [0:couple_pkg::N_COUPLE-1];

	// A reset entry has zero coupling, so the stage output settles to zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < couple_pkg::N_COUPLE; k++) begin
				mag_mem[k]    <= '0;
				offset_mem[k] <= '0;
			end
		end else if (cfg_we) begin
			mag_mem[cfg_addr]    <= cfg_mag;
			offset_mem[cfg_addr] <= cfg_offset;
		end
	end

	// Combinational reads, a write shows up the cycle after its strobe
	// The top level reads the two fields from different entries so that
	// the offset leads the magnitude by the one cycle of the phase adder
	assign mag    = mag_mem[mag_addr];
	assign offset = offset_mem[offset_addr];

endmodule

// File: source/iq_decode.sv
`timescale 1ns/1ps

// Decode stage
// Turns the interleaved drive stream into a steady complex value and
// forms the total rotation phase from the LO phase and coupling offset
module iq_decode (
	input  logic                                  clk,
	input  logic                                  rst,
	// High on the I sample, low on the Q sample that precedes it
	input  logic                                  iq,
	input  logic signed [couple_pkg::DATA_W-1:0]  drive,
	// Expected to hold for two cycles at a time
	input  logic [couple_pkg::PHASE_W-1:0]        lo_phase,
	input  logic [couple_pkg::PHASE_W-1:0]        offset,
	output logic [couple_pkg::PHASE_W-1:0]        phase,
	output logic signed [couple_pkg::DATA_W-1:0]  d_real,
	output logic signed [couple_pkg::DATA_W-1:0]  d_imag
);

	// Previous drive sample, which holds Q when iq is high
	logic signed [couple_pkg::DATA_W-1:0] drive_d1;

	always_ff @(posedge clk) begin
		if (rst) begin
			drive_d1 <= '0;
			d_real   <= '0;
			d_imag   <= '0;
		end else begin
			drive_d1 <= drive;
			// Capture the I/Q pair once per two cycles
			// Both halves then stay put until the next I sample
			if (iq) begin
				d_real <= drive;
				d_imag <= drive_d1;
			end
		end
	end

	// Total phase, the adder simply wraps at a full circle
	// This register is the one-cycle lag that the crossed read addresses
	// of the coupling bank make up for
	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
		end else begin
			phase <= lo_phase + offset;
		end
	end

endmodule

// File: source/pair_couple_top.sv
`timescale 1ns/1ps

// One coupling stage of the cavity field model
// Applies two complex couplings to an interleaved IQ drive and returns
// the real part of each product, interleaved on pair at one per clock.
// While iq is high pair carries entry 1, while iq is low entry 0
module pair_couple_top (
	input  logic                                  clk,
	input  logic                                  rst,
	// Interleaved drive stream, iq alternates every cycle
	input  logic                                  iq,
	input  logic signed [couple_pkg::DATA_W-1:0]  drive,
	input  logic [couple_pkg::PHASE_W-1:0]        lo_phase,
	// Host write port for the coupling bank
	input  logic                                  cfg_we,
	input  logic [couple_pkg::COUPLE_AW-1:0]      cfg_addr,
	input  logic signed [couple_pkg::DATA_W-1:0]  cfg_mag,
	input  logic [couple_pkg::PHASE_W-1:0]        cfg_offset,
	output logic signed [couple_pkg::OUT_W-1:0]   pair
);

	// Coupling fields read out of the bank
	logic signed [couple_pkg::DATA_W-1:0] mag;
	logic [couple_pkg::PHASE_W-1:0]       offset;

	// Decode stage outputs
	logic [couple_pkg::PHASE_W-1:0]       phase;
	logic signed [couple_pkg::DATA_W-1:0] d_real;
	logic signed [couple_pkg::DATA_W-1:0] d_imag;

	// Rotated coupling
	logic signed [couple_pkg::DATA_W-1:0] xout;
	logic signed [couple_pkg::DATA_W-1:0] yout;

	// The offset is read one entry ahead of the magnitude, since it passes
	// through the phase register first. Both halves of entry k then reach
	// the rotator in the same cycle
	coupling_regs u_regs (
		.clk         (clk),
		.rst         (rst),
		.cfg_we      (cfg_we),
		.cfg_addr    (cfg_addr),
		.cfg_mag     (cfg_mag),
		.cfg_offset  (cfg_offset),
		.mag_addr    (iq),
		.offset_addr (~iq),
		.mag         (mag),
		.offset      (offset)
	);

	iq_decode u_decode (
		.clk      (clk),
		.rst      (rst),
		.iq       (iq),
		.drive    (drive),
		.lo_phase (lo_phase),
		.offset   (offset),
		.phase    (phase),
		.d_real   (d_real),
		.d_imag   (d_imag)
	);

	cordic_rotate u_execute (
		.clk   (clk),
		.rst   (rst),
		.mag   (mag),
		.phase (phase),
		.xout  (xout),
		.yout  (yout)
	);

	couple_result u_result (
		.clk    (clk),
		.rst    (rst),
		.xout   (xout),
		.yout   (yout),
		.d_real (d_real),
		.d_imag (d_imag),
		.pair   (pair)
	);

endmodule
